// ==== verilog/outx_pkg.sv ====
// Shared widths, sequencer states and opcode constants for the block output unit.
// Every other file refers to these by scoped names.
package outx_pkg;

    // One register byte, memory byte or port byte.
    typedef logic [7:0] byte_t;

    // Memory address or 16-bit port address.
    typedef logic [15:0] addr_t;

    // XPT step number.
    typedef logic [4:0] xpt_t;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } step_state_t;

    // An iteration runs from step 4 through step 11.
    localparam xpt_t XPT_FIRST = 5'd4;
    localparam xpt_t XPT_LAST  = 5'd11;

    // Opcodes follow the ED-prefixed 101xx011 pattern.
    localparam byte_t OP_OUTI = 8'hA3;
    localparam byte_t OP_OUTD = 8'hAB;
    localparam byte_t OP_OTIR = 8'hB3;
    localparam byte_t OP_OTDR = 8'hBB;

    localparam int OP_DIR_BIT = 3; // Set for decrement of HL.
    localparam int OP_REP_BIT = 4; // Set for the repeating forms.

endpackage

// ==== verilog/xpt_sequencer.sv ====
// Step sequencer for the block output instructions.
// Latches the opcode on start and walks XPT from 4 to 11, looping for OTIR and OTDR.
`timescale 1ns/100ps

module xpt_sequencer (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  outx_pkg::byte_t opcode,
    input  logic            b_zero,
    output outx_pkg::xpt_t  xpt,
    output logic            run,
    output outx_pkg::byte_t opcode_q,
    output logic            busy,
    output logic            done
);

    outx_pkg::step_state_t state;
    logic                  op_valid;
    logic                  last_step;
    logic                  loop_again;

    // Only the four block output opcodes start a transfer.
    assign op_valid = (opcode == outx_pkg::OP_OUTI) ||
                      (opcode == outx_pkg::OP_OUTD) ||
                      (opcode == outx_pkg::OP_OTIR) ||
                      (opcode == outx_pkg::OP_OTDR);

    assign last_step  = (xpt == outx_pkg::XPT_LAST);
    assign loop_again = opcode_q[outx_pkg::OP_REP_BIT] && !b_zero; // b_zero is from B-1 at 11.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= outx_pkg::IDLE;
            xpt      <= '0;
            opcode_q <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                outx_pkg::IDLE: begin
                    if (start && op_valid) begin
                        state    <= outx_pkg::RUN;
                        xpt      <= outx_pkg::XPT_FIRST;
                        opcode_q <= opcode;
                    end
                end
                outx_pkg::RUN: begin
                    if (!last_step) begin
                        xpt <= xpt + 5'd1;
                    end else if (loop_again) begin
                        xpt <= outx_pkg::XPT_FIRST; // Next byte follows directly.
                    end else begin
                        state <= outx_pkg::IDLE;
                        xpt   <= '0;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= outx_pkg::IDLE;
                end
            endcase
        end
    end

    assign run  = (state == outx_pkg::RUN);
    assign busy = (state == outx_pkg::RUN); // Start and load are ignored while high.

endmodule

// ==== verilog/outx_decoder.sv ====
// Step decoder for OUTI, OTIR, OUTD and OTDR.
// Turns the current XPT step and opcode into per-step strobes, purely combinational.
`timescale 1ns/100ps

module outx_decoder (
    input  outx_pkg::xpt_t  xpt,
    input  logic            run,
    input  outx_pkg::byte_t opcode,
    output logic            mem_rd,
    output logic            write_dt,
    output logic            sel_ad_bc,
    output logic            b_calc,
    output logic            write_flags,
    output logic            hl_add,
    output logic            hl_sub,
    output logic            write_hl,
    output logic            io_wr,
    output logic            write_b
);

    logic       grp_4_7;
    logic       grp_8_11;
    logic [3:0] t_lo; // One-hot of steps 4..7.
    logic [3:0] t_hi; // One-hot of steps 8..11.
    logic       dir_down;

    // Upper step bits pick the group.
    assign grp_4_7  = run && (xpt[4:2] == 3'b001);
    assign grp_8_11 = run && (xpt[4:2] == 3'b010);

    // Low bits pick the step inside its group.
    always_comb begin
        t_lo = 4'b0000;
        t_hi = 4'b0000;
        if (grp_4_7) begin
            t_lo[xpt[1:0]] = 1'b1;
        end
        if (grp_8_11) begin
            t_hi[xpt[1:0]] = 1'b1;
        end
    end

    assign dir_down = opcode[outx_pkg::OP_DIR_BIT];

    // Memory read cycle.
    assign mem_rd   = t_lo[2];  // Step 6.
    assign write_dt = t_lo[3];  // Step 7.

    // Output cycle, BC drives the address bus throughout.
    assign sel_ad_bc = grp_8_11;

    // B-1 is needed for the flags at 8 and the write-back at 11.
    assign b_calc      = t_hi[0] | t_hi[3];
    assign write_flags = t_hi[0];

    assign hl_add   = t_hi[1] & ~dir_down;
    assign hl_sub   = t_hi[1] & dir_down;
    assign write_hl = t_hi[1];   // Step 9.

    assign io_wr   = t_hi[2];    // Step 10.
    assign write_b = t_hi[3];    // Step 11.

endmodule

// ==== verilog/block_regs.sv ====
// B, C, H, L and the data latch for the block output unit.
// Loaded from outside when idle, written back from memory and the ALU under decoder strobes.
`timescale 1ns/100ps

module block_regs (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  outx_pkg::byte_t reg_b,
    input  outx_pkg::byte_t reg_c,
    input  outx_pkg::byte_t reg_h,
    input  outx_pkg::byte_t reg_l,
    input  logic            write_dt,
    input  logic            write_hl,
    input  logic            write_b,
    input  outx_pkg::byte_t mem_rdata,
    input  outx_pkg::byte_t b_next,
    input  outx_pkg::addr_t hl_next,
    output outx_pkg::byte_t b,
    output outx_pkg::byte_t c,
    output outx_pkg::addr_t hl,
    output outx_pkg::byte_t data
);

    outx_pkg::byte_t h;
    outx_pkg::byte_t l;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            b <= '0;
            c <= '0;
            h <= '0;
            l <= '0;
        end else if (load) begin
            b <= reg_b;
            c <= reg_c;
            h <= reg_h;
            l <= reg_l;
        end else begin
            if (write_b) begin
                b <= b_next; // Counted down at step 11.
            end
            if (write_hl) begin
                h <= hl_next[15:8];
                l <= hl_next[7:0];
            end
        end
    end

    // Byte fetched at HL, held until the port write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data <= '0;
        end else if (write_dt) begin
            data <= mem_rdata;
        end
    end

    assign hl = {h, l};

endmodule

// ==== verilog/block_alu.sv ====
// Arithmetic for the block output unit.
// Decrements B, steps HL up or down, and keeps the Z and N flags.
`timescale 1ns/100ps

module block_alu (
    input  logic            clk,
    input  logic            arst_n,
    input  outx_pkg::byte_t b,
    input  outx_pkg::addr_t hl,
    input  outx_pkg::byte_t data,
    input  logic            b_calc,
    input  logic            write_flags,
    input  logic            hl_add,
    input  logic            hl_sub,
    output outx_pkg::byte_t b_next,
    output outx_pkg::addr_t hl_next,
    output logic            b_zero,
    output logic            flag_z,
    output logic            flag_n
);

    // B-1 only when the decoder asks for it, B otherwise.
    assign b_next = b_calc ? b - 8'd1 : b;

    always_comb begin
        if (hl_add) begin
            hl_next = hl + 16'd1;
        end else if (hl_sub) begin
            hl_next = hl - 16'd1; // Wraps from 0000 to FFFF.
        end else begin
            hl_next = hl;
        end
    end

    assign b_zero = (b_next == 8'h00);

    // Flags written at step 8.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_z <= 1'b0;
            flag_n <= 1'b0;
        end else if (write_flags) begin
            flag_z <= b_zero;
            flag_n <= data[7]; // N copies the top bit of the byte sent.
        end
    end

endmodule

// ==== verilog/outx_unit.sv ====
// Top of the block output unit: sequencer, decoder, registers and ALU.
// Memory reads and port writes are plain strobes with no handshake.
`timescale 1ns/100ps

module outx_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  outx_pkg::byte_t reg_b,
    input  outx_pkg::byte_t reg_c,
    input  outx_pkg::byte_t reg_h,
    input  outx_pkg::byte_t reg_l,
    input  logic            start,
    input  outx_pkg::byte_t opcode,
    output logic            mem_rd,
    output outx_pkg::addr_t mem_addr,
    input  outx_pkg::byte_t mem_rdata,
    output logic            io_wr,
    output outx_pkg::addr_t io_addr,
    output outx_pkg::byte_t io_wdata,
    output logic            busy,
    output logic            done,
    output logic            flag_z,
    output logic            flag_n
);

    outx_pkg::xpt_t  xpt;
    outx_pkg::byte_t opcode_q;
    outx_pkg::byte_t b;
    outx_pkg::byte_t c;
    outx_pkg::byte_t data;
    outx_pkg::byte_t b_next;
    outx_pkg::addr_t hl;
    outx_pkg::addr_t hl_next;
    logic            run;
    logic            b_zero;
    logic            load_idle;
    logic            write_dt;
    logic            sel_ad_bc;
    logic            b_calc;
    logic            write_flags;
    logic            hl_add;
    logic            hl_sub;
    logic            write_hl;
    logic            write_b;

    assign load_idle = load & ~busy;

    xpt_sequencer i_seq (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .opcode   (opcode),
        .b_zero   (b_zero),
        .xpt      (xpt),
        .run      (run),
        .opcode_q (opcode_q),
        .busy     (busy),
        .done     (done)
    );

    outx_decoder i_dec (
        .xpt         (xpt),
        .run         (run),
        .opcode      (opcode_q),
        .mem_rd      (mem_rd),
        .write_dt    (write_dt),
        .sel_ad_bc   (sel_ad_bc),
        .b_calc      (b_calc),
        .write_flags (write_flags),
        .hl_add      (hl_add),
        .hl_sub      (hl_sub),
        .write_hl    (write_hl),
        .io_wr       (io_wr),
        .write_b     (write_b)
    );

    block_regs i_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load_idle),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .reg_h     (reg_h),
        .reg_l     (reg_l),
        .write_dt  (write_dt),
        .write_hl  (write_hl),
        .write_b   (write_b),
        .mem_rdata (mem_rdata),
        .b_next    (b_next),
        .hl_next   (hl_next),
        .b         (b),
        .c         (c),
        .hl        (hl),
        .data      (data)
    );

    block_alu i_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .b           (b),
        .hl          (hl),
        .data        (data),
        .b_calc      (b_calc),
        .write_flags (write_flags),
        .hl_add      (hl_add),
        .hl_sub      (hl_sub),
        .b_next      (b_next),
        .hl_next     (hl_next),
        .b_zero      (b_zero),
        .flag_z      (flag_z),
        .flag_n      (flag_n)
    );

    assign mem_addr = hl;
    assign io_addr  = sel_ad_bc ? {b, c} : hl; // Shared address bus, BC in the output cycle.
    assign io_wdata = data;

endmodule

// ==== verif/outx_tb.sv ====
// Directed testbench for the block output unit: runs OUTI, OUTD, OTIR and OTDR against a
// combinational memory model and checks port writes, registers, flags and timing.
`timescale 1ns/100ps

module outx_tb;

    logic            clk;
    logic            arst_n;
    logic            load, start;
    outx_pkg::byte_t reg_b, reg_c, reg_h, reg_l, opcode;
    logic            mem_rd, io_wr, busy, done, flag_z, flag_n;
    outx_pkg::addr_t mem_addr, io_addr;
    outx_pkg::byte_t mem_rdata, io_wdata;

    logic [7:0]  mem [0:65535];
    logic [15:0] wr_addr_q[$]; // Port writes in the order seen.
    logic [7:0]  wr_data_q[$];
    int          wr_cycle_q[$];
    logic [15:0] rd_addr_q[$]; // Memory reads in the order seen.
    int          rd_cycle_q[$];
    int          cycle_cnt;
    int          start_ref; // Cycle count in the first cycle after the start edge.
    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    assign mem_rdata = mem[mem_addr]; // Answers in the same cycle.

    outx_unit i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .reg_h     (reg_h),
        .reg_l     (reg_l),
        .start     (start),
        .opcode    (opcode),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .io_wr     (io_wr),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .busy      (busy),
        .done      (done),
        .flag_z    (flag_z),
        .flag_n    (flag_n)
    );

    // Samples in mid-cycle where outputs are settled.
    always @(negedge clk) begin
        if (mem_rd) begin
            rd_addr_q.push_back(mem_addr);
            rd_cycle_q.push_back(cycle_cnt);
        end
        if (io_wr) begin
            wr_addr_q.push_back(io_addr);
            wr_data_q.push_back(io_wdata);
            wr_cycle_q.push_back(cycle_cnt);
        end
    end

    task random_byte(output logic [7:0] val);
        for (int i = 0; i < 8; i++) begin
            val  = {val[6:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
    endtask

    task fill_memory;
        logic [16:0] a;
        logic [7:0]  r;
        lfsr = 32'hbd10;
        for (a = '0; a < 17'h10000; a = a + 17'd1) begin
            random_byte(r);
            mem[a[15:0]] = r ^ a[15:8] ^ a[7:0];
        end
    endtask

    task check_value(string test, string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", test, what, expected, actual);
            errors++;
        end
    endtask

    task finish_test(string test, int e0);
        tests_run++;
        if (errors != e0) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test, errors - e0);
        end else begin
            $display("%s: ok", test);
        end
    endtask

    task load_regs(outx_pkg::byte_t b, outx_pkg::byte_t c, outx_pkg::addr_t hl);
        @(negedge clk);
        load  = 1'b1;
        reg_b = b;
        reg_c = c;
        reg_h = hl[15:8];
        reg_l = hl[7:0];
        @(negedge clk);
        load = 1'b0;
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_cycle_q.delete();
        rd_addr_q.delete();
        rd_cycle_q.delete();
    endtask

    task pulse_start(outx_pkg::byte_t op);
        @(negedge clk);
        start  = 1'b1;
        opcode = op;
        @(negedge clk);
        start     = 1'b0;
        start_ref = cycle_cnt;
    endtask

    // Waits on falling edges until done shows up.
    task wait_done(string test, int limit);
        int waited;
        waited = 0;
        while (!done && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", test, limit);
            errors++;
        end
    endtask

    // Step 6 of each iteration reads the byte at the current HL.
    task check_reads(string test, int n, outx_pkg::addr_t hl0, logic down);
        logic [15:0] a;
        check_value(test, "read count", 32'(n), 32'(rd_addr_q.size()));
        for (int i = 0; i < n && i < rd_addr_q.size(); i++) begin
            a = down ? hl0 - 16'(i) : hl0 + 16'(i);
            check_value(test, "read addr", 32'(a), 32'(rd_addr_q[i]));
            check_value(test, "read cycle", 32'(8 * i + 3), 32'(rd_cycle_q[i] - start_ref + 1));
        end
    endtask

    task check_writes(string test, int n, outx_pkg::byte_t b0, outx_pkg::byte_t c,
                      outx_pkg::addr_t hl0, logic down);
        logic [15:0] a;
        check_value(test, "write count", 32'(n), 32'(wr_addr_q.size()));
        for (int i = 0; i < n && i < wr_addr_q.size(); i++) begin
            a = down ? hl0 - 16'(i) : hl0 + 16'(i);
            check_value(test, "port addr", 32'({b0 - 8'(i), c}), 32'(wr_addr_q[i]));
            check_value(test, "port data", 32'(mem[a]), 32'(wr_data_q[i]));
            check_value(test, "write cycle", 32'(8 * i + 7), 32'(wr_cycle_q[i] - start_ref + 1));
        end
    endtask

    task check_end(string test, outx_pkg::byte_t b, outx_pkg::addr_t hl, logic z, logic n);
        check_value(test, "B", 32'(b), 32'(i_dut.i_regs.b));
        check_value(test, "HL", 32'(hl), 32'(mem_addr));
        check_value(test, "flag Z", 32'(z), 32'(flag_z));
        check_value(test, "flag N", 32'(n), 32'(flag_n));
    endtask

    task test_reset_idle;
        int e0;
        e0 = errors;
        check_value("reset_idle", "busy", 32'(0), 32'(busy));
        check_value("reset_idle", "done", 32'(0), 32'(done));
        check_value("reset_idle", "mem_rd", 32'(0), 32'(mem_rd));
        check_value("reset_idle", "io_wr", 32'(0), 32'(io_wr));
        check_value("reset_idle", "io_addr", 32'(0), 32'(io_addr));
        check_value("reset_idle", "io_wdata", 32'(0), 32'(io_wdata));
        check_end("reset_idle", 8'h00, 16'h0000, 1'b0, 1'b0);
        finish_test("reset_idle", e0);
    endtask

    // Runs one instruction over n_iter bytes and checks the end state.
    task run_transfer(string test, outx_pkg::byte_t op, logic down, int n_iter,
                      outx_pkg::byte_t b0, outx_pkg::byte_t c, outx_pkg::addr_t hl0);
        int              e0;
        outx_pkg::byte_t exp_b;
        outx_pkg::addr_t exp_hl;
        outx_pkg::addr_t last;
        e0     = errors;
        exp_b  = b0 - 8'(n_iter);
        exp_hl = down ? hl0 - 16'(n_iter) : hl0 + 16'(n_iter);
        last   = down ? hl0 - 16'(n_iter - 1) : hl0 + 16'(n_iter - 1);
        load_regs(b0, c, hl0);
        pulse_start(op);
        wait_done(test, 8 * n_iter + 8);
        check_value(test, "done latency", 32'(8 * n_iter + 1), 32'(cycle_cnt - start_ref + 1));
        check_value(test, "busy at done", 32'(0), 32'(busy));
        check_reads(test, n_iter, hl0, down);
        check_writes(test, n_iter, b0, c, hl0, down);
        check_end(test, exp_b, exp_hl, exp_b == 8'h00, mem[last][7]);
        finish_test(test, e0);
    endtask

    task test_busy_strobes;
        int e0;
        e0 = errors;
        load_regs(8'h02, 8'h11, 16'h4000);
        pulse_start(outx_pkg::OP_OTIR);
        check_value("busy_strobes", "busy", 32'(1), 32'(busy));
        load   = 1'b1; // Both strobes land inside the transfer.
        reg_b  = 8'h77;
        reg_c  = 8'h66;
        reg_h  = 8'h99;
        reg_l  = 8'h99;
        start  = 1'b1;
        opcode = outx_pkg::OP_OUTD;
        @(negedge clk);
        load  = 1'b0;
        start = 1'b0;
        wait_done("busy_strobes", 24);
        check_value("busy_strobes", "busy at done", 32'(0), 32'(busy));
        check_reads("busy_strobes", 2, 16'h4000, 1'b0);
        check_writes("busy_strobes", 2, 8'h02, 8'h11, 16'h4000, 1'b0);
        check_end("busy_strobes", 8'h00, 16'h4002, 1'b1, mem[16'h4001][7]);
        @(negedge clk);
        check_value("busy_strobes", "done after pulse", 32'(0), 32'(done));
        finish_test("busy_strobes", e0);
    endtask

    initial begin
        arst_n       = 1'b0;
        load         = 1'b0;
        start        = 1'b0;
        reg_b        = '0;
        reg_c        = '0;
        reg_h        = '0;
        reg_l        = '0;
        opcode       = '0;
        cycle_cnt    = 0;
        start_ref    = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fill_memory();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
        end
        arst_n = 1'b1;

        test_reset_idle();
        run_transfer("outi", outx_pkg::OP_OUTI, 1'b0, 1, 8'h01, 8'h34, 16'h1000);
        run_transfer("outd", outx_pkg::OP_OUTD, 1'b1, 1, 8'h12, 8'h56, 16'h2345);
        run_transfer("otir", outx_pkg::OP_OTIR, 1'b0, 5, 8'h05, 8'hA0, 16'h3000);
        run_transfer("otdr_wrap", outx_pkg::OP_OTDR, 1'b1, 3, 8'h03, 8'h55, 16'h0001);
        test_busy_strobes();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/outx_pkg.sv
verilog/xpt_sequencer.sv
verilog/outx_decoder.sv
verilog/block_regs.sv
verilog/block_alu.sv
verilog/outx_unit.sv
verif/outx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module outx_tb -f verilog.f --Mdir obj_dir -o outx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/outx_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
